//--- cus42_params.svh
`ifndef CUS42_PARAMS_SVH
`define CUS42_PARAMS_SVH

// raster size in pixels and lines
`define H_TOTAL 384
`define V_TOTAL 264

// bus and counter widths
`define PIXEL_W 9
`define BYTE_W 8
`define LAYER_ADDR_W 12
`define RAM_ADDR_W 13
`define PROM_ADDR_W 14

`define LAYER_COUNT 2	// scroll layers sharing one tile sram

// scroll register index within a layer
`define REG_H_LOW 0	// hscroll [7:0]
`define REG_H_HIGH 1	// hscroll bit 8 from data bit 0
`define REG_V 2	// vscroll [7:0]
`define REG_FLIP 3	// global flip, layer 0 only

`endif

//--- cus42_pkg.sv
`include "cus42_params.svh"

package cus42_pkg;

	////////////////////
	// vector types
	////////////////////

	// raster position or scroll offset
	typedef logic [`PIXEL_W-1:0] pixelCount;

	// cpu data bus and sram byte
	typedef logic [`BYTE_W-1:0] cpuByte;

	// full sram address, top bit is the layer
	typedef logic [`RAM_ADDR_W-1:0] ramAddr;

	// address within one layer's half of the sram
	typedef logic [`LAYER_ADDR_W-1:0] layerRamAddr;

	// graphics prom address
	typedef logic [`PROM_ADDR_W-1:0] promAddr;

	////////////////////
	// tile slot phases
	////////////////////

	// four clocks per tile slot, same as hCount[1:0]
	typedef enum logic [1:0] {
		phaseA = 2'd0,	// layer 0 even byte address
		phaseB = 2'd1,	// layer 0 odd byte address
		phaseC = 2'd2,	// layer 1 even byte address
		phaseD = 2'd3	// layer 1 odd byte address
	} fetchPhase;

endpackage

//--- videoTiming.sv
`timescale 1ns/1ns
`include "cus42_params.svh"

module videoTiming (
	input logic CLK_6M,
	input logic rst,
	output cus42_pkg::pixelCount hCount,	// 0 .. 383
	output cus42_pkg::pixelCount vCount	// 0 .. 263
);

	logic hWrap;	// last pixel of the line
	logic vWrap;	// last line of the frame

	assign hWrap = (hCount == cus42_pkg::pixelCount'(`H_TOTAL - 1));
	assign vWrap = (vCount == cus42_pkg::pixelCount'(`V_TOTAL - 1));

	////////////////////
	// horizontal
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hCount <= '0;
		end else if (hWrap) begin
			hCount <= '0;	// back to left edge
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	////////////////////
	// vertical
	////////////////////

	// advances once per line on the horizontal wrap
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			vCount <= '0;
		end else if (hWrap) begin
			if (vWrap) begin
				vCount <= '0;	// new frame
			end else begin
				vCount <= vCount + 1'b1;
			end
		end
	end

endmodule

//--- scrollRegs.sv
`timescale 1ns/1ns
`include "cus42_params.svh"

module scrollRegs (
	input logic CLK_6M,
	input logic rst,
	input logic regWrite,	// single cycle strobe
	input logic [2:0] regAddr,	// layer, then index
	input cus42_pkg::cpuByte regData,
	output cus42_pkg::pixelCount hScroll0,
	output cus42_pkg::pixelCount vScroll0,
	output cus42_pkg::pixelCount hScroll1,
	output cus42_pkg::pixelCount vScroll1,
	output logic flip
);

	// per layer storage
	cus42_pkg::pixelCount hScrollReg [`LAYER_COUNT];
	cus42_pkg::cpuByte vScrollReg [`LAYER_COUNT];	// bit 8 is never written

	logic regLayer;	// which layer the cpu addresses
	logic [1:0] regIndex;	// field within that layer

	assign regLayer = regAddr[2];
	assign regIndex = regAddr[1:0];

	////////////////////
	// cpu write decode
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			for (int i = 0; i < `LAYER_COUNT; i++) begin
				hScrollReg[i] <= '0;
				vScrollReg[i] <= '0;
			end
			flip <= 1'b0;
		end else if (regWrite) begin
			case (regIndex)
				2'(`REG_H_LOW): hScrollReg[regLayer][7:0] <= regData;
				2'(`REG_H_HIGH): hScrollReg[regLayer][8] <= regData[0];	// 9th bit only
				2'(`REG_V): vScrollReg[regLayer] <= regData;
				2'(`REG_FLIP): begin
					// flip lives on layer 0, layer 1 slot is dead
					if (!regLayer) begin
						flip <= regData[0];
					end
				end
				default: ;
			endcase
		end
	end

	// vertical offset tops out at 255
	assign hScroll0 = hScrollReg[0];
	assign vScroll0 = {1'b0, vScrollReg[0]};
	assign hScroll1 = hScrollReg[1];
	assign vScroll1 = {1'b0, vScrollReg[1]};

endmodule

//--- cus42Layer.sv
`timescale 1ns/1ns
`include "cus42_params.svh"

module cus42Layer #(
	parameter int ASSIGNED_LAYER = 0	// 0 fetches in A/B, 1 in C/D
) (
	input logic CLK_6M,
	input logic rst,
	input logic flip,
	input cus42_pkg::pixelCount hCount,
	input cus42_pkg::pixelCount vCount,
	input cus42_pkg::pixelCount hScroll,
	input cus42_pkg::pixelCount vScroll,
	input cus42_pkg::cpuByte rdData,	// sram data, one clock after ra
	output cus42_pkg::layerRamAddr ra,
	output cus42_pkg::promAddr ga,
	output logic gaStrobe	// ga valid this cycle
);

	// slot phases owned by this layer
	localparam cus42_pkg::fetchPhase FIRST_PHASE =
		(ASSIGNED_LAYER == 0) ? cus42_pkg::phaseA : cus42_pkg::phaseC;
	localparam cus42_pkg::fetchPhase SECOND_PHASE =
		(ASSIGNED_LAYER == 0) ? cus42_pkg::phaseB : cus42_pkg::phaseD;
	localparam cus42_pkg::fetchPhase THIRD_PHASE =
		(ASSIGNED_LAYER == 0) ? cus42_pkg::phaseC : cus42_pkg::phaseA;	// odd byte arrives

	cus42_pkg::fetchPhase phase;
	cus42_pkg::pixelCount fh;	// flipped raster column
	cus42_pkg::pixelCount hSum;
	cus42_pkg::pixelCount sh;
	cus42_pkg::pixelCount sv;
	cus42_pkg::pixelCount shLatch;	// coordinates held for the rest of the fetch
	cus42_pkg::pixelCount svLatch;
	cus42_pkg::cpuByte evenByte;	// tile code byte
	logic fetchBusy;	// address issued, strobe still owed

	assign phase = cus42_pkg::fetchPhase'(hCount[1:0]);

	////////////////////
	// scroll adders
	////////////////////

	// mirror by counting back from the line width
	assign fh = flip ? cus42_pkg::pixelCount'(`H_TOTAL - hCount) : hCount;
	assign hSum = hScroll + fh;	// wraps at 512
	// fine column runs backwards under flip
	assign sh = {hSum[8:3], flip ? ~hSum[2:0] : hSum[2:0]};
	assign sv = vScroll + vCount;

	////////////////////
	// sram address
	////////////////////

	// live sum in the first phase, held copy with bit 0 set after that
	assign ra = (phase == FIRST_PHASE) ? {sv[7:3], sh[8:3], 1'b0}
		: {svLatch[7:3], shLatch[8:3], 1'b1};

	// payload capture
	always_ff @(posedge CLK_6M) begin
		if (phase == FIRST_PHASE) begin
			shLatch <= sh;
			svLatch <= sv;
		end
		if (phase == SECOND_PHASE) begin
			evenByte <= rdData;	// read issued in first phase
		end
	end

	////////////////////
	// prom address out
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			fetchBusy <= 1'b0;
			gaStrobe <= 1'b0;
			ga <= '0;
		end else begin
			gaStrobe <= (phase == THIRD_PHASE) && fetchBusy;
			if (phase == FIRST_PHASE) begin
				fetchBusy <= 1'b1;
			end else if (phase == THIRD_PHASE) begin
				fetchBusy <= 1'b0;
			end
			if ((phase == THIRD_PHASE) && fetchBusy) begin
				// odd byte bank bits, code byte, fine row, nibble
				ga <= {rdData[1:0], evenByte, svLatch[2:0], shLatch[2]};
			end
		end
	end

endmodule

//--- tileRam.sv
`timescale 1ns/1ns
`include "cus42_params.svh"

module tileRam (
	input logic CLK_6M,
	input logic ramWrite,	// cpu strobe
	input cus42_pkg::ramAddr ramWrAddr,
	input cus42_pkg::cpuByte ramWrData,
	input cus42_pkg::fetchPhase phase,	// slot phase from hCount
	input cus42_pkg::layerRamAddr ra0,	// layer 0 video address
	input cus42_pkg::layerRamAddr ra1,	// layer 1 video address
	output cus42_pkg::cpuByte rdData	// one clock after address
);

	localparam int DEPTH = `LAYER_COUNT << `LAYER_ADDR_W;	// 8 KB

	cus42_pkg::cpuByte mem [DEPTH];

	logic rdLayer;	// current owner of the read port
	cus42_pkg::ramAddr rdAddr;

	////////////////////
	// read port arbitration
	////////////////////

	// layer 0 in A and B, layer 1 in C and D
	assign rdLayer = (phase == cus42_pkg::phaseC) || (phase == cus42_pkg::phaseD);
	assign rdAddr = rdLayer ? {1'b1, ra1} : {1'b0, ra0};	// layer bit on top

	////////////////////
	// array
	////////////////////

	always_ff @(posedge CLK_6M) begin
		if (ramWrite) begin
			mem[ramWrAddr] <= ramWrData;
		end
	end

	// registered video read
	always_ff @(posedge CLK_6M) begin
		rdData <= mem[rdAddr];
	end

endmodule

//--- cus42.sv
`timescale 1ns/1ns

module cus42 (
	input logic CLK_6M,
	input logic rst,
	// scroll register port
	input logic regWrite,
	input logic [2:0] regAddr,
	input cus42_pkg::cpuByte regData,
	// tile sram cpu port
	input logic ramWrite,
	input cus42_pkg::ramAddr ramWrAddr,
	input cus42_pkg::cpuByte ramWrData,
	// raster position
	output cus42_pkg::pixelCount hCount,
	output cus42_pkg::pixelCount vCount,
	// prom addresses
	output cus42_pkg::promAddr ga0,
	output logic gaStrobe0,
	output cus42_pkg::promAddr ga1,
	output logic gaStrobe1
);

	cus42_pkg::pixelCount hScroll0;
	cus42_pkg::pixelCount vScroll0;
	cus42_pkg::pixelCount hScroll1;
	cus42_pkg::pixelCount vScroll1;
	logic flip;
	cus42_pkg::fetchPhase phase;
	cus42_pkg::layerRamAddr ra0;
	cus42_pkg::layerRamAddr ra1;
	cus42_pkg::cpuByte rdData;	// shared by both layers

	assign phase = cus42_pkg::fetchPhase'(hCount[1:0]);

	////////////////////
	// timing and cpu side
	////////////////////

	videoTiming i_videoTiming (
		.CLK_6M(CLK_6M), .rst(rst),
		.hCount(hCount), .vCount(vCount)
	);

	scrollRegs i_scrollRegs (
		.CLK_6M(CLK_6M), .rst(rst),
		.regWrite(regWrite), .regAddr(regAddr), .regData(regData),
		.hScroll0(hScroll0), .vScroll0(vScroll0),
		.hScroll1(hScroll1), .vScroll1(vScroll1),
		.flip(flip)
	);

	tileRam i_tileRam (
		.CLK_6M(CLK_6M),
		.ramWrite(ramWrite), .ramWrAddr(ramWrAddr), .ramWrData(ramWrData),
		.phase(phase), .ra0(ra0), .ra1(ra1), .rdData(rdData)
	);

	////////////////////
	// layer engines
	////////////////////

	cus42Layer #(.ASSIGNED_LAYER(0)) i_layer0 (
		.CLK_6M(CLK_6M), .rst(rst), .flip(flip),
		.hCount(hCount), .vCount(vCount),
		.hScroll(hScroll0), .vScroll(vScroll0),
		.rdData(rdData), .ra(ra0), .ga(ga0), .gaStrobe(gaStrobe0)
	);

	cus42Layer #(.ASSIGNED_LAYER(1)) i_layer1 (	// two clocks behind layer 0
		.CLK_6M(CLK_6M), .rst(rst), .flip(flip),
		.hCount(hCount), .vCount(vCount),
		.hScroll(hScroll1), .vScroll(vScroll1),
		.rdData(rdData), .ra(ra1), .ga(ga1), .gaStrobe(gaStrobe1)
	);

endmodule

//--- tbClock.sv
`timescale 1ns/1ns

module tbClock #(
	parameter int PERIOD = 20	// ns, one CLK_6M cycle
) (
	output logic clk
);

	// low at time 0, first rising edge half a period later
	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

//--- cus42_checker.sv
`timescale 1ns/1ns
`include "cus42_params.svh"

module cus42_checker (
	input logic CLK_6M,
	input logic rst,
	input cus42_pkg::pixelCount hCount,
	input cus42_pkg::pixelCount vCount,
	input logic gaStrobe0,
	input logic gaStrobe1
);

	// sticky flags, one per assertion
	logic phase0Fail = 1'b0;
	logic phase1Fail = 1'b0;
	logic overlapFail = 1'b0;
	logic rangeFail = 1'b0;
	logic resetFail = 1'b0;
	logic anyFail;	// watched from the testbench

	assign anyFail = phase0Fail | phase1Fail | overlapFail | rangeFail | resetFail;

	////////////////////
	// strobe timing
	////////////////////

	strobe0InPhaseD: assert property (@(posedge CLK_6M) disable iff (rst)
		gaStrobe0 |-> (hCount[1:0] == cus42_pkg::phaseD))
		else begin
			phase0Fail = 1'b1;
			$error("gaStrobe0 high outside phaseD");
		end

	strobe1InPhaseB: assert property (@(posedge CLK_6M) disable iff (rst)
		gaStrobe1 |-> (hCount[1:0] == cus42_pkg::phaseB))
		else begin
			phase1Fail = 1'b1;
			$error("gaStrobe1 high outside phaseB");
		end

	strobesApart: assert property (@(posedge CLK_6M) disable iff (rst)
		!(gaStrobe0 && gaStrobe1))
		else begin
			overlapFail = 1'b1;
			$error("both layer strobes high together");
		end

	////////////////////
	// counters and reset
	////////////////////

	countersInRange: assert property (@(posedge CLK_6M) disable iff (rst)
		(hCount < `H_TOTAL) && (vCount < `V_TOTAL))
		else begin
			rangeFail = 1'b1;
			$error("raster counter past its limit");
		end

	strobesLowAfterReset: assert property (@(posedge CLK_6M)
		rst |=> (!gaStrobe0 && !gaStrobe1))
		else begin
			resetFail = 1'b1;
			$error("strobe high in the cycle after reset");
		end

endmodule

//--- cus42Tb.sv
`timescale 1ns/1ns
`include "cus42_params.svh"

module cus42Tb;

	localparam int RESET_CYCLES = 10;
	localparam int RAM_DEPTH = `LAYER_COUNT << `LAYER_ADDR_W;
	localparam int NUM_ROWS = 8;
	localparam int WRITES_PER_ROW = 8;

	// one scroll setup and how many strobes to check under it
	typedef struct packed {
		logic [8:0] hScroll0;
		logic [7:0] vScroll0;
		logic [8:0] hScroll1;
		logic [7:0] vScroll1;
		logic flip;
		logic flipLayer1;	// index 3 on layer 1, has no effect
		logic [15:0] strobes;	// both layers together
	} stimRow;

	logic CLK_6M;
	logic rst;
	logic regWrite;
	logic [2:0] regAddr;
	cus42_pkg::cpuByte regData;
	logic ramWrite;
	cus42_pkg::ramAddr ramWrAddr;
	cus42_pkg::cpuByte ramWrData;
	cus42_pkg::pixelCount hCount;
	cus42_pkg::pixelCount vCount;
	cus42_pkg::promAddr ga0;
	cus42_pkg::promAddr ga1;
	logic gaStrobe0;
	logic gaStrobe1;

	stimRow stimTable [NUM_ROWS];
	cus42_pkg::cpuByte ramCopy [RAM_DEPTH];	// mirror of the tile sram
	int modelH [`LAYER_COUNT];
	int modelV [`LAYER_COUNT];
	logic modelFlip;
	int seed = 65;
	int timeoutLimit;
	int cycleCount = 0;
	int rasterH = 0;	// expected raster position
	int rasterV = 0;

	tbClock #(.PERIOD(20)) i_tbClock (.clk(CLK_6M));

	cus42 i_cus42 (.*);

	bind cus42 cus42_checker i_checker (
		.CLK_6M(CLK_6M), .rst(rst), .hCount(hCount), .vCount(vCount),
		.gaStrobe0(gaStrobe0), .gaStrobe1(gaStrobe1)
	);

	////////////////////
	// helpers
	////////////////////

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("Error: %s expected 0x%0h got 0x%0h", name, expected, actual));
		end
	endtask

	// one cpu strobe, then an idle cycle
	task automatic writeReg(input logic layer, input int index, input cus42_pkg::cpuByte data);
		@(posedge CLK_6M);
		regWrite <= 1'b1;
		regAddr <= {layer, 2'(index)};
		regData <= data;
		@(posedge CLK_6M);
		regWrite <= 1'b0;
	endtask

	// reference prom address from raster position H, V of the first issue phase
	function automatic cus42_pkg::promAddr expectedGa(input int layer, input int h, input int v);
		int fh;
		int hSum;
		int sh;
		int sv;
		int evenAddr;
		fh = modelFlip ? `H_TOTAL - h : h;
		hSum = (modelH[layer] + fh) % 512;
		sh = modelFlip ? hSum ^ 7 : hSum;	// fine column mirrored
		sv = (modelV[layer] + v) % 512;
		evenAddr = (layer << 12) | (((sv >> 3) & 31) << 7) | (((sh >> 3) & 63) << 1);
		return {ramCopy[evenAddr | 1][1:0], ramCopy[evenAddr], 3'(sv & 7), 1'((sh >> 2) & 1)};
	endfunction

	////////////////////
	// raster reference
	////////////////////

	// one pixel per clock, line and frame wrap
	always @(posedge CLK_6M) begin
		if (rst) begin
			rasterH <= 0;
			rasterV <= 0;
		end else begin
			rasterH <= (rasterH + 1) % `H_TOTAL;
			if (rasterH == `H_TOTAL - 1) begin
				rasterV <= (rasterV + 1) % `V_TOTAL;	// next line on the wrap
			end
		end
	end

	////////////////////
	// watchdogs
	////////////////////

	always @(posedge CLK_6M) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > timeoutLimit) begin
			failRun($sformatf("The run timed out after %0d clock cycles", cycleCount));
		end
	end

	always @(negedge CLK_6M) begin
		if (i_cus42.i_checker.anyFail) begin
			failRun("An assertion in the bound checker failed");
		end
		checkValue("hCount", hCount, rasterH);
		checkValue("vCount", vCount, rasterV);
	end

	////////////////////
	// stimulus
	////////////////////

	initial begin
		stimRow row;
		int seen;
		int h;
		int v;
		rst = 1'b1;
		regWrite = 1'b0;
		regAddr = '0;
		regData = '0;
		ramWrite = 1'b0;
		ramWrAddr = '0;
		ramWrData = '0;
		// h0 v0 h1 v1 flip flipLayer1 strobes
		stimTable[0] = '{9'h000, 8'h00, 9'h000, 8'h00, 1'b0, 1'b0, 16'd48};	// zero scroll
		stimTable[1] = '{9'h005, 8'h00, 9'h0a3, 8'h00, 1'b0, 1'b0, 16'd48};
		stimTable[2] = '{9'h1c4, 8'h00, 9'h12f, 8'h00, 1'b0, 1'b0, 16'd64};	// above 255
		stimTable[3] = '{9'h000, 8'h07, 9'h000, 8'hf9, 1'b0, 1'b0, 16'd48};	// top wrap
		stimTable[4] = '{9'h133, 8'hfe, 9'h0ff, 8'h3c, 1'b0, 1'b0, 16'd200};
		stimTable[5] = '{9'h000, 8'h00, 9'h011, 8'h22, 1'b1, 1'b0, 16'd96};	// flip held
		stimTable[6] = '{9'h07d, 8'h41, 9'h1e0, 8'h90, 1'b0, 1'b1, 16'd96};	// stays unflipped
		stimTable[7] = '{9'h1ff, 8'h80, 9'h100, 8'hc8, 1'b1, 1'b1, 16'd400};	// crosses lines
		timeoutLimit = RESET_CYCLES + 16 + RAM_DEPTH + 1 + 200;
		for (int r = 0; r < NUM_ROWS; r++) begin
			timeoutLimit += WRITES_PER_ROW * 2 + 4 + stimTable[r].strobes * 4;
		end

		repeat (RESET_CYCLES) @(posedge CLK_6M);
		rst <= 1'b0;

		// idle outputs until layer 0 completes its first fetch
		do begin
			@(negedge CLK_6M);
			if (!gaStrobe0) begin
				checkValue("ga0", ga0, 0);
				checkValue("ga1", ga1, 0);
				checkValue("gaStrobe1", gaStrobe1, 0);
			end
		end while (!gaStrobe0);
		checkValue("hCount", hCount, 3);	// first issue at hCount 0

		// random tile attributes, copy kept for the model
		for (int a = 0; a < RAM_DEPTH; a++) begin
			ramCopy[a] = cus42_pkg::cpuByte'($random(seed));
			@(posedge CLK_6M);
			ramWrite <= 1'b1;
			ramWrAddr <= cus42_pkg::ramAddr'(a);
			ramWrData <= ramCopy[a];
		end
		@(posedge CLK_6M);
		ramWrite <= 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			row = stimTable[r];
			writeReg(1'b0, `REG_H_LOW, row.hScroll0[7:0]);
			writeReg(1'b0, `REG_H_HIGH, {7'd0, row.hScroll0[8]});
			writeReg(1'b0, `REG_V, row.vScroll0);
			writeReg(1'b1, `REG_H_LOW, row.hScroll1[7:0]);
			writeReg(1'b1, `REG_H_HIGH, {7'd0, row.hScroll1[8]});
			writeReg(1'b1, `REG_V, row.vScroll1);
			writeReg(1'b0, `REG_FLIP, {7'd0, row.flip});
			writeReg(1'b1, `REG_FLIP, {7'd0, row.flipLayer1});
			modelH[0] = row.hScroll0;
			modelV[0] = row.vScroll0;
			modelH[1] = row.hScroll1;
			modelV[1] = row.vScroll1;
			modelFlip = row.flip;	// only the layer 0 write counts
			repeat (4) @(posedge CLK_6M);	// one tile slot
			seen = 0;
			while (seen < row.strobes) begin
				@(negedge CLK_6M);
				if (gaStrobe0) begin
					checkValue("ga0", ga0, expectedGa(0, hCount - 3, vCount));
					seen++;
				end
				if (gaStrobe1) begin
					h = hCount;
					h = h - 3;
					v = vCount;
					// issue was on the previous line
					if (h < 0) begin
						h += `H_TOTAL;
						v = (v == 0) ? `V_TOTAL - 1 : v - 1;
					end
					checkValue("ga1", ga1, expectedGa(1, h, v));
					seen++;
				end
			end
		end

		if (!i_cus42.i_checker.anyFail) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			failRun("An assertion in the bound checker failed");
		end
	end

endmodule

//--- src.f
+incdir+.
cus42_pkg.sv
videoTiming.sv
scrollRegs.sv
cus42Layer.sv
tileRam.sv
cus42.sv
tbClock.sv
cus42_checker.sv
cus42Tb.sv

//--- Bender.yml
package:
  name: cus42

sources:
  - include_dirs:
      - .
    files:
      - cus42_pkg.sv
      - videoTiming.sv
      - scrollRegs.sv
      - cus42Layer.sv
      - tileRam.sv
      - cus42.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbClock.sv
      - cus42_checker.sv
      - cus42Tb.sv
